/* design/bpred_config.svh */
// Sizing defines for the fetch front end: BTB entry count, history width and reset PC
`ifndef BPRED_CONFIG_SVH
`define BPRED_CONFIG_SVH

// Number of BTB entries, must be a power of two
`define BPRED_BTB_ENTRIES 32

// Global history width, also sets PHT depth to 2**BPRED_GHR_BITS
`define BPRED_GHR_BITS 5

// First fetch address after reset
`define BPRED_RESET_PC 32'h0000_0000

`endif

/* design/rv_isa_pkg.sv */
// ISA package with the control-instruction kind enum and the instruction width
`default_nettype none

package rv_isa_pkg;

    // Control kinds, decoded outside from the 7-bit opcode
    // (branch 1100011, jal 1101111, jalr 1100111)
    typedef enum logic [1:0] {
        CTRL_NONE   = 2'b00,
        CTRL_BRANCH = 2'b01,
        CTRL_JAL    = 2'b10,
        CTRL_JALR   = 2'b11
    } ctrl_op_e;

    // Sequential PC step
    localparam logic [31:0] INSTR_BYTES = 32'd4;

endpackage

`default_nettype wire

/* design/bpred_pkg.sv */
// Predictor package with counter states and the lookup, fetch and resolve packets
`default_nettype none

`include "bpred_config.svh"

package bpred_pkg;

    import rv_isa_pkg::*;

    typedef logic [`BPRED_GHR_BITS-1:0] pht_index_t;

    // Two-bit saturating counter, MSB set means predict taken
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } pht_state_e;

    // Combined BTB and PHT result for the current PC
    typedef struct packed {
        logic       hit;
        logic       is_jump;
        logic       is_branch;
        logic [31:0] target;
        pht_index_t pht_index;
        logic       counter_taken;
    } lookup_t;

    // Packet handed to decode
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        pred_taken;
        logic [31:0] pred_target;
        pht_index_t  pht_index;
    } fetch_t;

    // Outcome of one control instruction reported by execute
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        ctrl_op_e    op;
        logic        taken;
        logic [31:0] target;
        pht_index_t  pht_index;
        logic        redirect;
    } resolve_t;

endpackage

`default_nettype wire

/* design/fetch_pc_stage.sv */
// PC register with redirect, stall and predicted next-PC selection
`timescale 1ns/1ns
`default_nettype none

`include "bpred_config.svh"

module fetch_pc_stage
    import rv_isa_pkg::*;
    import bpred_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        stall_i,
    input  wire resolve_t    resolve_i,
    input  wire lookup_t     lookup_i,
    output      logic [31:0] pc_o
);

    logic [31:0] pc_q;
    logic [31:0] pc_plus4;
    logic [31:0] redirect_pc;
    logic [31:0] predicted_pc;
    logic        pred_taken;
    logic        redirect;

    assign pc_plus4 = pc_q + INSTR_BYTES;

    // Jumps always go to the stored target, branches follow the counter
    assign pred_taken = lookup_i.hit &&
                        (lookup_i.is_jump || (lookup_i.is_branch && lookup_i.counter_taken));
    assign predicted_pc = pred_taken ? lookup_i.target : pc_plus4;

    // Mispredict recovery from execute
    assign redirect = resolve_i.valid && resolve_i.redirect;
    assign redirect_pc = resolve_i.taken ? resolve_i.target : resolve_i.pc + INSTR_BYTES;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `BPRED_RESET_PC;
        end else if (redirect) begin
            pc_q <= redirect_pc;
        end else if (!stall_i) begin
            pc_q <= predicted_pc;
        end
    end

    assign pc_o = pc_q;

    // Targets from both the BTB and execute must keep fetch word aligned
    pc_aligned_a: assert property (@(posedge clk) disable iff (reset_i)
        pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/branch_target_buffer.sv */
// Direct-mapped BTB with full-PC tags, lookup and allocation on taken resolves
`timescale 1ns/1ns
`default_nettype none

`include "bpred_config.svh"

module branch_target_buffer
    import rv_isa_pkg::*;
    import bpred_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic [31:0] pc_i,
    input  wire resolve_t    resolve_i,
    output      logic        hit_o,
    output      logic        is_jump_o,
    output      logic        is_branch_o,
    output      logic [31:0] target_o
);

    localparam int unsigned ENTRIES  = `BPRED_BTB_ENTRIES;
    localparam int unsigned IDX_BITS = $clog2(ENTRIES);

    logic [31:0]        tag_q    [ENTRIES];
    logic [31:0]        target_q [ENTRIES];
    logic               jump_q   [ENTRIES];
    logic               branch_q [ENTRIES];
    logic [ENTRIES-1:0] valid_q;

    logic [IDX_BITS-1:0] rd_idx;
    logic [IDX_BITS-1:0] wr_idx;
    logic                wr_en;

    // Word-aligned PC bits select the entry
    assign rd_idx = pc_i[IDX_BITS+1:2];
    assign wr_idx = resolve_i.pc[IDX_BITS+1:2];

    // Only taken control flow is worth a BTB entry
    assign wr_en = resolve_i.valid && (resolve_i.op != CTRL_NONE) && resolve_i.taken;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= resolve_i.pc;
            target_q[wr_idx] <= resolve_i.target;
            jump_q[wr_idx]   <= (resolve_i.op == CTRL_JAL) || (resolve_i.op == CTRL_JALR);
            branch_q[wr_idx] <= (resolve_i.op == CTRL_BRANCH);
        end
    end

    // Full PC compare, so aliasing PCs never hit on each other's entry
    assign hit_o       = valid_q[rd_idx] && (tag_q[rd_idx] == pc_i);
    assign is_jump_o   = hit_o && jump_q[rd_idx];
    assign is_branch_o = hit_o && branch_q[rd_idx];
    assign target_o    = target_q[rd_idx];

    // Targets stored from execute must keep predicted fetch word aligned
    target_aligned_a: assert property (@(posedge clk) disable iff (reset_i)
        hit_o |-> (target_o[1:0] == 2'b00));

endmodule

`default_nettype wire

/* design/gshare_predictor.sv */
// Gshare direction predictor with global history and two-bit counter table
`timescale 1ns/1ns
`default_nettype none

`include "bpred_config.svh"

module gshare_predictor
    import rv_isa_pkg::*;
    import bpred_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic [31:0] pc_i,
    input  wire resolve_t    resolve_i,
    input  wire logic        ghr_clear_i,
    output      logic        counter_taken_o,
    output      pht_index_t  pht_index_o
);

    localparam int unsigned GHR_BITS  = `BPRED_GHR_BITS;
    localparam int unsigned PHT_DEPTH = 1 << GHR_BITS;

    logic [GHR_BITS-1:0] ghr_q;
    pht_state_e          pht_q [PHT_DEPTH];
    pht_state_e          rd_state;
    logic                branch_upd;

    // Saturating step of one counter
    function automatic pht_state_e step_counter(pht_state_e cur, logic up);
        pht_state_e nxt;
        nxt = cur;
        unique case (cur)
            STRONG_NT: nxt = up ? WEAK_NT  : STRONG_NT;
            WEAK_NT:   nxt = up ? WEAK_T   : STRONG_NT;
            WEAK_T:    nxt = up ? STRONG_T : WEAK_NT;
            STRONG_T:  nxt = up ? STRONG_T : WEAK_T;
        endcase
        return nxt;
    endfunction

    assign pht_index_o     = pc_i[GHR_BITS+1:2] ^ ghr_q;
    assign rd_state        = pht_q[pht_index_o];
    assign counter_taken_o = (rd_state == WEAK_T) || (rd_state == STRONG_T);

    assign branch_upd = resolve_i.valid && (resolve_i.op == CTRL_BRANCH);

    // Execute returns the index used at fetch time, so no history replay here
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < PHT_DEPTH; i++) begin
                pht_q[i] <= STRONG_NT;
            end
        end else if (branch_upd) begin
            pht_q[resolve_i.pht_index] <= step_counter(pht_q[resolve_i.pht_index],
                                                       resolve_i.taken);
        end
    end

    // Newest outcome enters at the top bit
    always_ff @(posedge clk) begin
        if (reset_i || ghr_clear_i) begin
            ghr_q <= '0;
        end else if (branch_upd) begin
            ghr_q <= {resolve_i.taken, ghr_q[GHR_BITS-1:1]};
        end
    end

    // The index travels through decode and execute before it comes back
    index_known_a: assert property (@(posedge clk) disable iff (reset_i)
        branch_upd |-> !$isunknown(resolve_i.pht_index));

endmodule

`default_nettype wire

/* design/bpred_frontend.sv */
// Fetch front end top level with PC stage, BTB, gshare and the fetch output register
`timescale 1ns/1ns
`default_nettype none

module bpred_frontend
    import rv_isa_pkg::*;
    import bpred_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset_i,
    input  wire logic     stall_i,
    input  wire resolve_t resolve_i,
    input  wire logic     ghr_clear_i,
    output      fetch_t   fetch_o
);

    logic [31:0] pc;
    lookup_t     lookup;
    logic        btb_hit;
    logic        btb_jump;
    logic        btb_branch;
    logic [31:0] btb_target;
    logic        counter_taken;
    pht_index_t  pht_index;

    logic        pred_taken;
    logic [31:0] pred_target;

    logic        valid_q;
    logic [31:0] pc_q;
    logic        pred_taken_q;
    logic [31:0] pred_target_q;
    pht_index_t  pht_index_q;

    fetch_pc_stage u_pc_stage (
        .clk       (clk),
        .reset_i   (reset_i),
        .stall_i   (stall_i),
        .resolve_i (resolve_i),
        .lookup_i  (lookup),
        .pc_o      (pc)
    );

    branch_target_buffer u_btb (
        .clk         (clk),
        .reset_i     (reset_i),
        .pc_i        (pc),
        .resolve_i   (resolve_i),
        .hit_o       (btb_hit),
        .is_jump_o   (btb_jump),
        .is_branch_o (btb_branch),
        .target_o    (btb_target)
    );

    gshare_predictor u_gshare (
        .clk             (clk),
        .reset_i         (reset_i),
        .pc_i            (pc),
        .resolve_i       (resolve_i),
        .ghr_clear_i     (ghr_clear_i),
        .counter_taken_o (counter_taken),
        .pht_index_o     (pht_index)
    );

    assign lookup = '{hit: btb_hit, is_jump: btb_jump, is_branch: btb_branch,
                      target: btb_target, pht_index: pht_index,
                      counter_taken: counter_taken};

    // Same decision the PC stage makes, reported to decode
    assign pred_taken  = lookup.hit &&
                         (lookup.is_jump || (lookup.is_branch && lookup.counter_taken));
    assign pred_target = pred_taken ? lookup.target : pc + INSTR_BYTES;

    // Redirect squashes the wrong-path packet even while stalled
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (resolve_i.valid && resolve_i.redirect) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_q          <= pc;
            pred_taken_q  <= pred_taken;
            pred_target_q <= pred_target;
            pht_index_q   <= lookup.pht_index;
        end
    end

    assign fetch_o = '{valid: valid_q, pc: pc_q, pred_taken: pred_taken_q,
                       pred_target: pred_target_q, pht_index: pht_index_q};

endmodule

`default_nettype wire

/* sim/bpred_frontend_tb.sv */
// Testbench for the fetch front end with an LCG stimulus source and a reference model
`timescale 1ns/1ns
`default_nettype none

`include "bpred_config.svh"

module bpred_frontend_tb
    import rv_isa_pkg::*;
    import bpred_pkg::*;
;

    localparam int unsigned BTB_ENTRIES  = `BPRED_BTB_ENTRIES;
    localparam int unsigned BTB_IDX_BITS = $clog2(BTB_ENTRIES);
    localparam int unsigned GHR_BITS     = `BPRED_GHR_BITS;
    localparam int unsigned PHT_DEPTH    = 1 << GHR_BITS;

    logic     clk = 1'b0;
    logic     reset_i;
    logic     stall_i;
    resolve_t resolve_i;
    logic     ghr_clear_i;
    fetch_t   fetch_o;

    // Reference model state
    logic        m_btb_valid  [BTB_ENTRIES];
    logic [31:0] m_btb_tag    [BTB_ENTRIES];
    logic [31:0] m_btb_target [BTB_ENTRIES];
    logic        m_btb_jump   [BTB_ENTRIES];
    logic        m_btb_branch [BTB_ENTRIES];
    pht_state_e  m_pht        [PHT_DEPTH];
    pht_index_t  m_ghr;
    logic [31:0] m_pc;
    fetch_t      m_fetch;

    logic [31:0] rng_state = 32'hedca_aaec;
    int unsigned mismatches = 0;
    int unsigned timeouts = 0;

    bpred_frontend uut (
        .clk         (clk),
        .reset_i     (reset_i),
        .stall_i     (stall_i),
        .resolve_i   (resolve_i),
        .ghr_clear_i (ghr_clear_i),
        .fetch_o     (fetch_o)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Eight PCs with some sharing a BTB index
    function automatic logic [31:0] pool_addr(input logic [2:0] k);
        case (k)
            3'd0: return 32'h0000_0010;
            3'd1: return 32'h0000_0090;
            3'd2: return 32'h0000_0110;
            3'd3: return 32'h0000_0024;
            3'd4: return 32'h0000_0048;
            3'd5: return 32'h0000_00c8;
            3'd6: return 32'h0000_0200;
            default: return 32'h0000_0abc;
        endcase
    endfunction

    function automatic resolve_t make_resolve(input ctrl_op_e op, input logic [31:0] pc,
                                              input logic taken, input logic [31:0] target,
                                              input pht_index_t idx, input logic redirect);
        resolve_t r;
        r = '{valid: 1'b1, pc: pc, op: op, taken: taken, target: target,
              pht_index: idx, redirect: redirect};
        return r;
    endfunction

    function automatic pht_state_e train_counter(input pht_state_e s, input logic taken);
        if (taken) begin
            return (s == STRONG_T) ? s : pht_state_e'(s + 2'd1);
        end
        return (s == STRONG_NT) ? s : pht_state_e'(s - 2'd1);
    endfunction

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("Mismatch at %0t ns: %s", $time, msg);
    endtask

    // One clock edge of the model for the inputs now on the DUT
    task automatic model_step(input logic rst, input logic stall, input resolve_t res,
                              input logic clr);
        int unsigned bi;
        int unsigned wi;
        pht_index_t  pi;
        logic        pt;
        logic [31:0] ptarget;
        logic        redirect;
        bi = m_pc[BTB_IDX_BITS+1:2];
        pi = m_pc[GHR_BITS+1:2] ^ m_ghr;
        pt = m_btb_valid[bi] && (m_btb_tag[bi] == m_pc) && (m_btb_jump[bi] ||
             (m_btb_branch[bi] && (m_pht[pi] == WEAK_T || m_pht[pi] == STRONG_T)));
        ptarget = pt ? m_btb_target[bi] : m_pc + 32'd4;
        redirect = res.valid && res.redirect;
        if (rst) begin
            m_pc = `BPRED_RESET_PC;
            m_ghr = '0;
            m_fetch.valid = 1'b0;
            for (int i = 0; i < BTB_ENTRIES; i++) m_btb_valid[i] = 1'b0;
            for (int i = 0; i < PHT_DEPTH; i++) m_pht[i] = STRONG_NT;
        end else begin
            if (redirect) m_fetch.valid = 1'b0;
            else if (!stall) m_fetch.valid = 1'b1;
            if (!stall) begin
                m_fetch.pc = m_pc;
                m_fetch.pred_taken = pt;
                m_fetch.pred_target = ptarget;
                m_fetch.pht_index = pi;
            end
            if (redirect) m_pc = res.taken ? res.target : res.pc + 32'd4;
            else if (!stall) m_pc = ptarget;
            if (res.valid && res.op != CTRL_NONE && res.taken) begin
                wi = res.pc[BTB_IDX_BITS+1:2];
                m_btb_valid[wi] = 1'b1;
                m_btb_tag[wi] = res.pc;
                m_btb_target[wi] = res.target;
                m_btb_jump[wi] = (res.op == CTRL_JAL) || (res.op == CTRL_JALR);
                m_btb_branch[wi] = (res.op == CTRL_BRANCH);
            end
            if (res.valid && res.op == CTRL_BRANCH) begin
                m_pht[res.pht_index] = train_counter(m_pht[res.pht_index], res.taken);
                m_ghr = {res.taken, m_ghr[GHR_BITS-1:1]};
            end
            if (clr) m_ghr = '0;
        end
    endtask

    task automatic check_fetch();
        assert (fetch_o.valid === m_fetch.valid)
            else report_mismatch($sformatf("valid %b, expected %b", fetch_o.valid, m_fetch.valid));
        if (m_fetch.valid) begin
            assert (fetch_o.pc === m_fetch.pc && fetch_o.pred_taken === m_fetch.pred_taken &&
                    fetch_o.pred_target === m_fetch.pred_target &&
                    fetch_o.pht_index === m_fetch.pht_index)
                else report_mismatch($sformatf(
                    "packet pc %h taken %b target %h idx %h, expected %h %b %h %h",
                    fetch_o.pc, fetch_o.pred_taken, fetch_o.pred_target, fetch_o.pht_index,
                    m_fetch.pc, m_fetch.pred_taken, m_fetch.pred_target, m_fetch.pht_index));
        end
    endtask

    // Drive one cycle of inputs, then compare the packet after the edge
    task automatic apply(input logic stall, input resolve_t res, input logic clr);
        stall_i = stall;
        resolve_i = res;
        ghr_clear_i = clr;
        model_step(reset_i, stall, res, clr);
        @(posedge clk);
        #1;
        check_fetch();
    endtask

    task automatic idle(input int n);
        for (int i = 0; i < n; i++) apply(1'b0, '0, 1'b0);
    endtask

    task automatic wait_for_pc(input logic [31:0] pc);
        int n;
        n = 0;
        while (!(fetch_o.valid && fetch_o.pc == pc) && n < 64) begin
            idle(1);
            n++;
        end
        if (!(fetch_o.valid && fetch_o.pc == pc)) begin
            timeouts++;
            $display("Timeout: fetch never reached pc %h", pc);
        end
    endtask

    task automatic redirect_check(input resolve_t r, input logic clr, input logic [31:0] exp_pc);
        apply(1'b0, r, clr);
        assert (!fetch_o.valid) else report_mismatch("packet after redirect not squashed");
        idle(1);
        assert (fetch_o.valid && fetch_o.pc == exp_pc)
            else report_mismatch($sformatf("fetch resumed at %h, expected %h", fetch_o.pc, exp_pc));
    endtask

    initial begin
        resolve_t    r;
        fetch_t      held;
        logic [31:0] a;
        logic [31:0] b;
        int          n;
        reset_i = 1'b1;
        stall_i = 1'b0;
        resolve_i = '0;
        ghr_clear_i = 1'b0;
        m_pc = `BPRED_RESET_PC;
        idle(5);
        reset_i = 1'b0;

        // Reset release and sequential stepping
        n = 0;
        while (!fetch_o.valid && n < 16) begin
            idle(1);
            n++;
        end
        if (!fetch_o.valid) begin
            timeouts++;
            $display("Timeout: no valid fetch packet after reset");
        end
        assert (fetch_o.pc == `BPRED_RESET_PC) else report_mismatch("first packet not at reset PC");
        for (int i = 0; i < 6; i++) begin
            idle(1);
            assert (fetch_o.pc == `BPRED_RESET_PC + 32'd4 * (i + 1))
                else report_mismatch("PC did not step by four");
        end

        // JAL allocation and predicted target
        apply(1'b0, make_resolve(CTRL_JAL, 32'h40, 1'b1, 32'h100, '0, 1'b0), 1'b0);
        wait_for_pc(32'h40);
        assert (fetch_o.pred_taken && fetch_o.pred_target == 32'h100)
            else report_mismatch("JAL entry not predicted taken");
        idle(1);
        assert (fetch_o.pc == 32'h100) else report_mismatch("fetch did not follow JAL target");

        // Branch counter saturation at index zero
        apply(1'b0, make_resolve(CTRL_BRANCH, 32'h200, 1'b1, 32'h180, '0, 1'b0), 1'b0);
        for (int i = 0; i < 3; i++)
            apply(1'b0, make_resolve(CTRL_BRANCH, 32'h200, 1'b0, 32'h180, '0, 1'b0), 1'b0);
        redirect_check(make_resolve(CTRL_NONE, 32'h1fc, 1'b1, 32'h200, '0, 1'b1), 1'b1, 32'h200);
        assert (!fetch_o.pred_taken && fetch_o.pht_index == '0)
            else report_mismatch("branch predicted taken after not-taken training");
        for (int i = 0; i < 2; i++)
            apply(1'b0, make_resolve(CTRL_BRANCH, 32'h200, 1'b1, 32'h180, '0, 1'b0), 1'b0);
        redirect_check(make_resolve(CTRL_NONE, 32'h1fc, 1'b1, 32'h200, '0, 1'b1), 1'b1, 32'h200);
        assert (fetch_o.pred_taken && fetch_o.pred_target == 32'h180)
            else report_mismatch("two taken resolves did not flip the prediction");

        // Not-taken redirect followed by a taken one
        redirect_check(make_resolve(CTRL_BRANCH, 32'h300, 1'b0, 32'h380, pht_index_t'(3), 1'b1),
                       1'b0, 32'h304);
        redirect_check(make_resolve(CTRL_JALR, 32'h310, 1'b1, 32'h400, '0, 1'b1), 1'b0, 32'h400);

        // Stall holds the packet while the BTB still trains
        held = fetch_o;
        for (int i = 0; i < 4; i++) begin
            r = (i == 1) ? make_resolve(CTRL_JAL, 32'h408, 1'b1, 32'h80, '0, 1'b0) : '0;
            apply(1'b1, r, 1'b0);
            assert (fetch_o === held) else report_mismatch("fetch packet changed during stall");
        end
        for (int i = 0; i < 3; i++)
            apply(1'b0, make_resolve(CTRL_BRANCH, 32'h500, 1'b1, 32'h600, pht_index_t'(7), 1'b0),
                  1'b0);
        apply(1'b0, '0, 1'b1);
        idle(1);
        assert (fetch_o.pht_index == fetch_o.pc[GHR_BITS+1:2])
            else report_mismatch("history not cleared");

        // Long random run
        for (int i = 0; i < 600; i++) begin
            a = next_rand();
            b = next_rand();
            r = '0;
            if (a[29]) begin
                r = make_resolve(ctrl_op_e'(a[22:21]), pool_addr(a[25:23]), a[20],
                                 pool_addr(b[31:29]), pht_index_t'(b[23:16]), b[15:14] == 2'b00);
            end
            apply(a[31:30] == 2'b00, r, b[13:9] == 5'd0);
        end

        $display("Checks done: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bpred_frontend.f */
+incdir+design
design/rv_isa_pkg.sv
design/bpred_pkg.sv
design/fetch_pc_stage.sv
design/branch_target_buffer.sv
design/gshare_predictor.sv
design/bpred_frontend.sv
sim/bpred_frontend_tb.sv

/* Bender.yml */
package:
  name: bpred_frontend

sources:
  - include_dirs:
      - design
    files:
      - design/rv_isa_pkg.sv
      - design/bpred_pkg.sv
      - design/fetch_pc_stage.sv
      - design/branch_target_buffer.sv
      - design/gshare_predictor.sv
      - design/bpred_frontend.sv
  - target: test
    include_dirs:
      - design
    files:
      - sim/bpred_frontend_tb.sv
